// File: tb.f
+incdir+common
common/isa_pkg.sv
common/ctrl_pkg.sv
verilog/fetch_unit.sv
decode/decode_unit.sv
verilog/reg_file.sv
verilog/alu.sv
data_mem/data_mem.sv
verilog/writeback_unit.sv
verilog/minirv_core.sv
bench/tb_minirv.sv

// File: Makefile
VERILATOR  ?= verilator
TOP        ?= tb_minirv
FILELIST   ?= tb.f
BUILD_DIR  ?= obj_dir
VFLAGS     ?= --timing --assert
LINT_FLAGS ?= --lint-only
PASS_TEXT  ?= Simulation passed

.PHONY: all lint build sim clean

all: sim

lint:
	$(VERILATOR) $(LINT_FLAGS) $(VFLAGS) -f $(FILELIST) --top-module $(TOP)

build:
	$(VERILATOR) --binary $(VFLAGS) -f $(FILELIST) --top-module $(TOP) --Mdir $(BUILD_DIR)

sim: build
	@out="$$(./$(BUILD_DIR)/V$(TOP))"; echo "$$out"; \
	echo "$$out" | grep -qx "$(PASS_TEXT)"

clean:
	rm -rf $(BUILD_DIR)

// File: bench/tb_minirv.sv
`timescale 1ns/1ps
`default_nettype none

`include "core_settings.svh"

module tb_minirv;

    localparam int          AW         = $clog2(`MINIRV_DMEM_WORDS);
    localparam int          RUN_LENGTH = 2000;
    localparam logic [31:0] NOP        = 32'h0000_0013; // addi x0, x0, 0
    localparam logic [1:0]  CLS_ALU    = 2'd0;
    localparam logic [1:0]  CLS_LOAD   = 2'd1;
    localparam logic [1:0]  CLS_LINK   = 2'd2;

    logic        clk;
    logic        rst_n;
    logic [31:0] imem_addr, imem_data, retire_pc, retire_wdata;
    logic        retire_valid, retire_we;
    logic [3:0]  retire_rd;

    // reference model of the architectural state
    logic [31:0] model_regs [`MINIRV_NREGS];
    logic [31:0] model_mem [`MINIRV_DMEM_WORDS];
    logic [31:0] model_pc;
    logic        pending;
    int          retired;

    logic [3:0]    nx_rd; // effects of the instruction now on the port
    logic          nx_we, nx_store;
    logic [31:0]   nx_wdata, nx_store_word, nx_next_pc;
    logic [AW-1:0] nx_store_idx;
    logic [1:0]    nx_cls;

    // expected retire values change together with imem_data
    logic        exp_valid, exp_we;
    logic [31:0] exp_pc, exp_wdata;
    logic [3:0]  exp_rd;
    logic [1:0]  exp_cls;

    minirv_core dut0 (
        .clk(clk), .rst_n(rst_n),
        .imem_addr(imem_addr), .imem_data(imem_data),
        .retire_valid(retire_valid), .retire_we(retire_we),
        .retire_pc(retire_pc), .retire_wdata(retire_wdata), .retire_rd(retire_rd)
    );

    always #5 clk = ~clk;

    task automatic abort_run();
        $display("Simulation failed");
        $fatal(1);
    endtask

    task automatic report_mismatch(input string test, input logic [31:0] expected,
                                   input logic [31:0] actual);
        $display("error: %s expected %h actual %h", test, expected, actual);
        abort_run();
    endtask

    function automatic logic [2:0] random_alu_f3();
        case ($urandom_range(4, 0))
            0:       return isa_pkg::F3_ADD;
            1:       return isa_pkg::F3_SLT;
            2:       return isa_pkg::F3_XOR;
            3:       return isa_pkg::F3_OR;
            default: return isa_pkg::F3_AND;
        endcase
    endfunction

    function automatic logic [31:0] random_instr();
        logic [4:0]  rd, rs1, rs2;
        logic [2:0]  f3;
        logic [6:0]  f7;
        logic [11:0] imm12, mem_word, mem_byte, jalr_off;
        logic [20:0] joff;
        rd  = {1'b0, 4'($urandom_range(15, 0))};
        rs1 = {1'b0, 4'($urandom_range(15, 0))};
        rs2 = {1'b0, 4'($urandom_range(15, 0))};
        f3  = random_alu_f3();
        f7  = isa_pkg::F7_BASE;
        if (f3 == isa_pkg::F3_ADD && $urandom_range(1, 0) == 1) f7 = isa_pkg::F7_SUB;
        imm12    = 12'($urandom());
        mem_word = 12'($urandom_range(31, 0) * 4); // small window so loads hit earlier stores
        mem_byte = 12'($urandom_range(127, 0));
        joff     = 21'(($urandom_range(32, 0) - 16) * 4);
        jalr_off = 12'($urandom_range(63, 0) * 4 + $urandom_range(1, 0)); // bit 0 may be set
        case ($urandom_range(10, 0))
            0, 1: return {f7, rs2, rs1, f3, rd, isa_pkg::OP};
            2, 3: return {imm12, rs1, f3, rd, isa_pkg::OP_IMM};
            4:    return {20'($urandom()), rd, isa_pkg::LUI};
            5:    return {mem_word, 5'd0, isa_pkg::F3_W, rd, isa_pkg::LOAD};
            6:    return {mem_byte, 5'd0, isa_pkg::F3_BU, rd, isa_pkg::LOAD};
            7:    return {mem_word[11:5], rs2, 5'd0, isa_pkg::F3_W, mem_word[4:0], isa_pkg::STORE};
            8:    return {mem_byte[11:5], rs2, 5'd0, isa_pkg::F3_B, mem_byte[4:0], isa_pkg::STORE};
            9:    return {joff[20], joff[10:1], joff[11], joff[19:12], rd, isa_pkg::JAL};
            default: return {jalr_off, 5'd0, 3'b000, rd, isa_pkg::JALR};
        endcase
    endfunction

    ////////////////////////////////////////////////////////////////////////////
    // reference ISA model
    ////////////////////////////////////////////////////////////////////////////

    task automatic model_execute(input logic [31:0] instr);
        isa_pkg::instr_u w;
        logic [31:0]     a, b, opb, imm_i, imm_s, imm_j, addr, res, mword;
        logic [4:0]      sh;
        logic            writes;
        w      = instr;
        a      = model_regs[w.r.rs1[3:0]];
        b      = model_regs[w.r.rs2[3:0]];
        imm_i  = {{20{instr[31]}}, instr[31:20]};
        imm_s  = {{20{instr[31]}}, instr[31:25], instr[11:7]};
        imm_j  = {{12{instr[31]}}, instr[19:12], instr[20], instr[30:21], 1'b0};
        opb    = (w.r.opcode == isa_pkg::OP) ? b : imm_i;
        writes = 1'b1;
        res    = '0;
        addr   = '0;
        nx_store   = 1'b0;
        nx_cls     = CLS_ALU;
        nx_next_pc = model_pc + 32'd4;
        case (w.r.opcode)
            isa_pkg::OP, isa_pkg::OP_IMM: begin
                case (w.r.funct3)
                    isa_pkg::F3_ADD: begin
                        if (w.r.opcode == isa_pkg::OP && w.r.funct7 == isa_pkg::F7_SUB) begin
                            res = a - opb;
                        end else begin
                            res = a + opb;
                        end
                    end
                    isa_pkg::F3_SLT: res = ($signed(a) < $signed(opb)) ? 32'd1 : 32'd0;
                    isa_pkg::F3_XOR: res = a ^ opb;
                    isa_pkg::F3_OR:  res = a | opb;
                    isa_pkg::F3_AND: res = a & opb;
                    default:         writes = 1'b0;
                endcase
            end
            isa_pkg::LUI: res = {instr[31:12], 12'b0};
            isa_pkg::LOAD: begin
                addr   = a + imm_i;
                mword  = model_mem[addr[AW+1:2]];
                sh     = {addr[1:0], 3'b000};
                mword  = (w.i.funct3 == isa_pkg::F3_BU) ? ((mword >> sh) & 32'hff) : mword;
                res    = mword;
                nx_cls = CLS_LOAD;
            end
            isa_pkg::STORE: begin
                writes = 1'b0;
                addr   = a + imm_s;
                sh     = {addr[1:0], 3'b000};
                mword  = model_mem[addr[AW+1:2]];
                if (w.s.funct3 == isa_pkg::F3_B) begin
                    mword = (mword & ~(32'hff << sh)) | ({24'd0, b[7:0]} << sh);
                end else begin
                    mword = b;
                end
                nx_store      = 1'b1;
                nx_store_idx  = addr[AW+1:2];
                nx_store_word = mword;
            end
            isa_pkg::JAL: begin
                res        = model_pc + 32'd4;
                nx_next_pc = model_pc + imm_j;
                nx_cls     = CLS_LINK;
            end
            isa_pkg::JALR: begin
                res        = model_pc + 32'd4;
                nx_next_pc = (a + imm_i) & ~32'd1;
                nx_cls     = CLS_LINK;
            end
            default: writes = 1'b0;
        endcase
        nx_rd    = w.r.rd[3:0];
        nx_we    = writes && nx_rd != 4'd0; // x0 stays zero in the model
        nx_wdata = res;
    endtask

    task automatic model_commit();
        if (nx_we) model_regs[nx_rd] = nx_wdata;
        if (nx_store) model_mem[nx_store_idx] = nx_store_word;
        model_pc = nx_next_pc;
        retired++;
    endtask

    // commit the retiring instruction, then drive the next one
    always @(posedge clk) begin
        logic [31:0] instr;
        if (rst_n) begin
            if (pending) model_commit();
            instr = random_instr();
            model_execute(instr);
            pending = 1'b1;
            imem_data <= instr;
            exp_valid <= 1'b1;
            exp_pc    <= model_pc;
            exp_we    <= nx_we;
            exp_rd    <= nx_rd;
            exp_wdata <= nx_wdata;
            exp_cls   <= nx_cls;
        end
    end

    ////////////////////////////////////////////////////////////////////////////
    // checks
    ////////////////////////////////////////////////////////////////////////////

    quiet_a: assert property (@(posedge clk) disable iff (!rst_n) !exp_valid |-> !retire_valid)
        else report_mismatch("retire_valid before start", 32'd0, 32'($sampled(retire_valid)));
    first_addr_a: assert property (@(posedge clk) disable iff (!rst_n)
        !exp_valid |-> imem_addr == `MINIRV_RESET_PC)
        else report_mismatch("reset pc", `MINIRV_RESET_PC, $sampled(imem_addr));
    valid_a: assert property (@(posedge clk) disable iff (!rst_n) exp_valid |-> retire_valid)
        else report_mismatch("retire_valid", 32'd1, 32'($sampled(retire_valid)));
    addr_a: assert property (@(posedge clk) disable iff (!rst_n) exp_valid |-> imem_addr == exp_pc)
        else report_mismatch("imem_addr", $sampled(exp_pc), $sampled(imem_addr));
    pc_a: assert property (@(posedge clk) disable iff (!rst_n) exp_valid |-> retire_pc == exp_pc)
        else report_mismatch("retire_pc", $sampled(exp_pc), $sampled(retire_pc));
    we_a: assert property (@(posedge clk) disable iff (!rst_n) exp_valid |-> retire_we == exp_we)
        else report_mismatch("retire_we", 32'($sampled(exp_we)), 32'($sampled(retire_we)));
    rd_a: assert property (@(posedge clk) disable iff (!rst_n)
        exp_valid && exp_we |-> retire_rd == exp_rd)
        else report_mismatch("retire_rd", 32'($sampled(exp_rd)), 32'($sampled(retire_rd)));
    alu_a: assert property (@(posedge clk) disable iff (!rst_n)
        exp_valid && exp_we && exp_cls == CLS_ALU |-> retire_wdata == exp_wdata)
        else report_mismatch("alu result", $sampled(exp_wdata), $sampled(retire_wdata));
    load_a: assert property (@(posedge clk) disable iff (!rst_n)
        exp_valid && exp_we && exp_cls == CLS_LOAD |-> retire_wdata == exp_wdata)
        else report_mismatch("load data", $sampled(exp_wdata), $sampled(retire_wdata));
    link_a: assert property (@(posedge clk) disable iff (!rst_n)
        exp_valid && exp_we && exp_cls == CLS_LINK |-> retire_wdata == exp_wdata)
        else report_mismatch("link value", $sampled(exp_wdata), $sampled(retire_wdata));

    initial begin
        int cycles;
        void'($urandom(32'h11f10e90));
        clk       = 1'b0;
        rst_n     = 1'b0;
        imem_data = NOP;
        exp_valid = 1'b0;
        exp_we    = 1'b0;
        exp_pc    = '0;
        exp_rd    = '0;
        exp_wdata = '0;
        exp_cls   = CLS_ALU;
        pending   = 1'b0;
        retired   = 0;
        model_pc  = `MINIRV_RESET_PC;
        for (int i = 0; i < `MINIRV_NREGS; i++) model_regs[i] = '0;
        for (int i = 0; i < `MINIRV_DMEM_WORDS; i++) model_mem[i] = '0;

        repeat (10) @(posedge clk);
        rst_n <= 1'b1;

        cycles = 0;
        while (!retire_valid && cycles < 20) begin
            @(negedge clk);
            cycles++;
        end
        if (!retire_valid) begin
            $display("the core did not start retiring after reset was released");
            abort_run();
        end

        cycles = 0;
        while (retired < RUN_LENGTH && cycles < 2 * RUN_LENGTH) begin
            @(negedge clk);
            cycles++;
        end
        if (retired < RUN_LENGTH) begin
            $display("timeout with only %0d instructions retired", retired);
            abort_run();
        end else begin
            $display("Simulation passed");
            $finish;
        end
    end

endmodule

`default_nettype wire

// File: verilog/minirv_core.sv
`timescale 1ns/1ps
`default_nettype none

module minirv_core (
    input  logic        clk,
    input  logic        rst_n,
    output logic [31:0] imem_addr,
    input  logic [31:0] imem_data,
    output logic        retire_valid,
    output logic        retire_we,
    output logic [31:0] retire_pc,
    output logic [31:0] retire_wdata,
    output logic [3:0]  retire_rd
);

    logic [31:0]        pc, imm, rs1_val, rs2_val, alu_b, alu_result;
    logic [31:0]        mem_rdata, wb_data, jump_target;
    logic [3:0]         rs1, rs2, rd;
    logic               started, jump_taken, use_imm, reg_write;
    logic               mem_read, mem_write, is_jal, is_jalr, reg_we, store_en;
    ctrl_pkg::alu_op_e  alu_op;
    ctrl_pkg::mem_len_e mem_len;
    ctrl_pkg::wb_sel_e  wb_sel;

    ////////////////////////////////////////////////////////////////////////////
    // nothing commits until the fetch unit reports that the core has started
    ////////////////////////////////////////////////////////////////////////////

    assign reg_we   = reg_write & started;
    assign store_en = mem_write & started;
    assign alu_b    = use_imm ? imm : rs2_val;

    fetch_unit fetch0 (
        .clk(clk), .rst_n(rst_n),
        .jump_taken(jump_taken), .jump_target(jump_target),
        .pc(pc), .started(started)
    );

    decode_unit decode0 (
        .instr(imem_data),
        .rs1(rs1), .rs2(rs2), .rd(rd), .imm(imm),
        .use_imm(use_imm), .reg_write(reg_write),
        .mem_read(mem_read), .mem_write(mem_write),
        .is_jal(is_jal), .is_jalr(is_jalr),
        .alu_op(alu_op), .mem_len(mem_len), .wb_sel(wb_sel)
    );

    reg_file regs0 (
        .clk(clk), .rst_n(rst_n),
        .rs1(rs1), .rs2(rs2), .rd(rd),
        .we(reg_we), .wd(wb_data),
        .rs1_val(rs1_val), .rs2_val(rs2_val)
    );

    alu alu0 (.alu_op(alu_op), .a(rs1_val), .b(alu_b), .result(alu_result));

    // loads and stores use the alu sum as their address
    data_mem dmem0 (
        .clk(clk), .rst_n(rst_n),
        .read(mem_read), .write(store_en), .len(mem_len),
        .addr(alu_result), .wdata(rs2_val), .rdata(mem_rdata)
    );

    writeback_unit wb0 (
        .pc(pc), .imm(imm), .rs1_val(rs1_val),
        .alu_result(alu_result), .mem_rdata(mem_rdata),
        .wb_sel(wb_sel), .is_jal(is_jal), .is_jalr(is_jalr),
        .wb_data(wb_data), .jump_taken(jump_taken), .jump_target(jump_target)
    );

    assign imem_addr    = pc;
    assign retire_valid = started;
    assign retire_pc    = pc;
    assign retire_rd    = rd;
    assign retire_we    = reg_we;
    assign retire_wdata = wb_data;

endmodule

`default_nettype wire

// File: verilog/writeback_unit.sv
`timescale 1ns/1ps
`default_nettype none

module writeback_unit (
    input  logic [31:0]       pc,
    input  logic [31:0]       imm,
    input  logic [31:0]       rs1_val,
    input  logic [31:0]       alu_result,
    input  logic [31:0]       mem_rdata,
    input  ctrl_pkg::wb_sel_e wb_sel,
    input  logic              is_jal,
    input  logic              is_jalr,
    output logic [31:0]       wb_data,
    output logic              jump_taken,
    output logic [31:0]       jump_target
);

    always_comb begin
        case (wb_sel)
            ctrl_pkg::LINK: wb_data = pc + 32'd4;
            ctrl_pkg::MEM:  wb_data = mem_rdata;
            default:        wb_data = alu_result;
        endcase
    end

    assign jump_taken = is_jal | is_jalr;

    // jalr drops bit 0 of its sum
    assign jump_target = is_jalr ? ((rs1_val + imm) & ~32'd1) : pc + imm;

endmodule

`default_nettype wire

// File: data_mem/data_mem.sv
`timescale 1ns/1ps
`default_nettype none

`include "core_settings.svh"

module data_mem (
    input  logic               clk,
    input  logic               rst_n,
    input  logic               read,
    input  logic               write,
    input  ctrl_pkg::mem_len_e len,
    input  logic [31:0]        addr,
    input  logic [31:0]        wdata,
    output logic [31:0]        rdata
);

    localparam int AW = $clog2(`MINIRV_DMEM_WORDS);

    logic [31:0]   mem [`MINIRV_DMEM_WORDS];
    logic [AW-1:0] idx;
    logic [1:0]    lane;
    logic [31:0]   word;

    assign idx  = addr[AW+1:2]; // upper address bits wrap around the depth
    assign lane = addr[1:0];
    assign word = mem[idx];

    always_comb begin
        if (!read) begin
            rdata = '0;
        end else if (len == ctrl_pkg::BYTE_U) begin
            rdata = {24'b0, word[lane*8 +: 8]};
        end else begin
            rdata = word;
        end
    end

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            for (int i = 0; i < `MINIRV_DMEM_WORDS; i++) begin
                mem[i] <= '0;
            end
        end else if (write) begin
            if (len == ctrl_pkg::BYTE_U) begin
                mem[idx][lane*8 +: 8] <= wdata[7:0]; // only the addressed lane changes
            end else begin
                mem[idx] <= wdata;
            end
        end
    end

    ////////////////////////////////////////////////////////////////////////////
    // word accesses from the core must sit on a word boundary
    ////////////////////////////////////////////////////////////////////////////

    word_aligned_a: assert property (@(posedge clk) disable iff (!rst_n)
        (read || write) && len == ctrl_pkg::WORD |-> addr[1:0] == 2'b00)
        else $error("data_mem: misaligned word access at %h", addr);

endmodule

`default_nettype wire

// File: verilog/alu.sv
`timescale 1ns/1ps
`default_nettype none

module alu (
    input  ctrl_pkg::alu_op_e alu_op,
    input  logic [31:0]       a,
    input  logic [31:0]       b,
    output logic [31:0]       result
);

    always_comb begin
        case (alu_op)
            ctrl_pkg::ADD:    result = a + b;
            ctrl_pkg::SUB:    result = a - b;
            ctrl_pkg::AND:    result = a & b;
            ctrl_pkg::OR:     result = a | b;
            ctrl_pkg::XOR:    result = a ^ b;
            ctrl_pkg::SLT:    result = {31'b0, $signed(a) < $signed(b)}; // signed compare
            ctrl_pkg::PASS_B: result = b;
            default:          result = '0;
        endcase
    end

endmodule

`default_nettype wire

// File: verilog/reg_file.sv
`timescale 1ns/1ps
`default_nettype none

`include "core_settings.svh"

module reg_file (
    input  logic        clk,
    input  logic        rst_n,
    input  logic [3:0]  rs1,
    input  logic [3:0]  rs2,
    input  logic [3:0]  rd,
    input  logic        we,
    input  logic [31:0] wd,
    output logic [31:0] rs1_val,
    output logic [31:0] rs2_val
);

    logic [31:0] regs [`MINIRV_NREGS];

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            for (int i = 0; i < `MINIRV_NREGS; i++) begin
                regs[i] <= '0;
            end
        end else if (we && rd != 4'd0) begin
            regs[rd] <= wd;
        end
    end

    // x0 is never written, so it reads back as zero
    assign rs1_val = regs[rs1];
    assign rs2_val = regs[rs2];

endmodule

`default_nettype wire

// File: decode/decode_unit.sv
`timescale 1ns/1ps
`default_nettype none

module decode_unit (
    input  logic [31:0]        instr,
    output logic [3:0]         rs1,
    output logic [3:0]         rs2,
    output logic [3:0]         rd,
    output logic [31:0]        imm,
    output logic               use_imm,
    output logic               reg_write,
    output logic               mem_read,
    output logic               mem_write,
    output logic               is_jal,
    output logic               is_jalr,
    output ctrl_pkg::alu_op_e  alu_op,
    output ctrl_pkg::mem_len_e mem_len,
    output ctrl_pkg::wb_sel_e  wb_sel
);

    isa_pkg::instr_u w;
    logic [31:0]     imm_i, imm_s, imm_j, imm_u;
    logic            known, bad_funct, hi_reg;

    assign w = instr;

    assign rs1 = w.r.rs1[3:0]; // RV32E only has x0 to x15
    assign rs2 = w.r.rs2[3:0];
    assign rd  = w.r.rd[3:0];

    assign imm_i = {{20{w.i.imm12[11]}}, w.i.imm12};
    assign imm_s = {{20{w.s.imm_hi[6]}}, w.s.imm_hi, w.s.imm_lo};
    assign imm_u = {w.u.imm20, 12'b0};
    // J immediate is scattered across the upper twenty bits
    assign imm_j = {{12{w.u.imm20[19]}}, w.u.imm20[7:0], w.u.imm20[8], w.u.imm20[18:9], 1'b0};

    always_comb begin
        imm       = '0;
        use_imm   = 1'b0;
        reg_write = 1'b0;
        mem_read  = 1'b0;
        mem_write = 1'b0;
        is_jal    = 1'b0;
        is_jalr   = 1'b0;
        alu_op    = ctrl_pkg::ADD;
        mem_len   = ctrl_pkg::WORD;
        wb_sel    = ctrl_pkg::ALU;
        known     = 1'b1;
        bad_funct = 1'b0;
        hi_reg    = 1'b0;

        case (w.r.opcode)
            isa_pkg::OP, isa_pkg::OP_IMM: begin
                reg_write = 1'b1;
                use_imm   = (w.r.opcode == isa_pkg::OP_IMM);
                imm       = imm_i;
                hi_reg    = w.r.rd[4] | w.r.rs1[4] | (!use_imm & w.r.rs2[4]);
                case (w.r.funct3)
                    isa_pkg::F3_ADD: alu_op = (!use_imm && w.r.funct7 == isa_pkg::F7_SUB) ?
                                              ctrl_pkg::SUB : ctrl_pkg::ADD;
                    isa_pkg::F3_SLT: alu_op = ctrl_pkg::SLT;
                    isa_pkg::F3_XOR: alu_op = ctrl_pkg::XOR;
                    isa_pkg::F3_OR:  alu_op = ctrl_pkg::OR;
                    isa_pkg::F3_AND: alu_op = ctrl_pkg::AND;
                    default:         bad_funct = 1'b1;
                endcase
                // only add may carry the sub marker in funct7
                if (!use_imm && w.r.funct7 != isa_pkg::F7_BASE &&
                    !(w.r.funct7 == isa_pkg::F7_SUB && w.r.funct3 == isa_pkg::F3_ADD)) begin
                    bad_funct = 1'b1;
                end
            end
            isa_pkg::LUI: begin
                reg_write = 1'b1;
                use_imm   = 1'b1;
                imm       = imm_u;
                alu_op    = ctrl_pkg::PASS_B;
                hi_reg    = w.u.rd[4];
            end
            isa_pkg::LOAD: begin
                reg_write = 1'b1;
                mem_read  = 1'b1;
                use_imm   = 1'b1;
                imm       = imm_i;
                wb_sel    = ctrl_pkg::MEM;
                hi_reg    = w.i.rd[4] | w.i.rs1[4];
                if (w.i.funct3 == isa_pkg::F3_BU) mem_len = ctrl_pkg::BYTE_U;
                else bad_funct = (w.i.funct3 != isa_pkg::F3_W);
            end
            isa_pkg::STORE: begin
                mem_write = 1'b1;
                use_imm   = 1'b1;
                imm       = imm_s;
                hi_reg    = w.s.rs1[4] | w.s.rs2[4];
                if (w.s.funct3 == isa_pkg::F3_B) mem_len = ctrl_pkg::BYTE_U;
                else bad_funct = (w.s.funct3 != isa_pkg::F3_W);
            end
            isa_pkg::JAL: begin
                reg_write = 1'b1;
                is_jal    = 1'b1;
                imm       = imm_j;
                wb_sel    = ctrl_pkg::LINK;
                hi_reg    = w.u.rd[4];
            end
            isa_pkg::JALR: begin
                reg_write = 1'b1;
                is_jalr   = 1'b1;
                imm       = imm_i;
                wb_sel    = ctrl_pkg::LINK;
                hi_reg    = w.i.rd[4] | w.i.rs1[4];
                bad_funct = (w.i.funct3 != 3'b000);
            end
            default: known = 1'b0;
        endcase

        // anything not fully understood retires as a no-op
        if (!known || bad_funct) begin
            reg_write = 1'b0;
            mem_read  = 1'b0;
            mem_write = 1'b0;
            is_jal    = 1'b0;
            is_jalr   = 1'b0;
        end
        if (rd == 4'd0) reg_write = 1'b0; // x0 writes never retire

        if (known) begin
            assert (!bad_funct && !hi_reg)
                else $error("decode: unsupported encoding %h", instr);
        end
    end

endmodule

`default_nettype wire

// File: verilog/fetch_unit.sv
`timescale 1ns/1ps
`default_nettype none

`include "core_settings.svh"

module fetch_unit (
    input  logic        clk,
    input  logic        rst_n,
    input  logic        jump_taken,
    input  logic [31:0] jump_target,
    output logic [31:0] pc,
    output logic        started
);

    // the pc holds until the core has started, so the reset-pc word retires first
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            pc      <= `MINIRV_RESET_PC;
            started <= 1'b0;
        end else begin
            started <= 1'b1;
            if (started) begin
                pc <= jump_taken ? jump_target : pc + 32'd4;
            end
        end
    end

    // jump targets come from the write-back stage
    pc_aligned_a: assert property (@(posedge clk) disable iff (!rst_n) pc[1:0] == 2'b00)
        else $error("fetch: pc %h is not word aligned", pc);

endmodule

`default_nettype wire

// File: common/ctrl_pkg.sv
`default_nettype none

package ctrl_pkg;

    typedef enum logic [2:0] {
        ADD,
        SUB,
        AND,
        OR,
        XOR,
        SLT,
        PASS_B // lui routes the immediate straight through
    } alu_op_e;

    typedef enum logic [1:0] {
        WORD,
        BYTE_U
    } mem_len_e;

    // source of the register write-back value
    typedef enum logic [1:0] {
        ALU,
        MEM,
        LINK
    } wb_sel_e;

endpackage

`default_nettype wire

// File: common/isa_pkg.sv
`default_nettype none

package isa_pkg;

    // major opcodes of the supported subset
    typedef enum logic [6:0] {
        OP     = 7'b0110011,
        OP_IMM = 7'b0010011,
        LUI    = 7'b0110111,
        LOAD   = 7'b0000011,
        STORE  = 7'b0100011,
        JAL    = 7'b1101111,
        JALR   = 7'b1100111
    } opcode_e;

    localparam logic [2:0] F3_ADD = 3'b000;
    localparam logic [2:0] F3_SLT = 3'b010;
    localparam logic [2:0] F3_XOR = 3'b100;
    localparam logic [2:0] F3_OR  = 3'b110;
    localparam logic [2:0] F3_AND = 3'b111;
    localparam logic [2:0] F3_W   = 3'b010; // lw and sw
    localparam logic [2:0] F3_BU  = 3'b100; // lbu
    localparam logic [2:0] F3_B   = 3'b000; // sb

    localparam logic [6:0] F7_BASE = 7'b0000000;
    localparam logic [6:0] F7_SUB  = 7'b0100000;

    typedef struct packed {
        logic [6:0] funct7;
        logic [4:0] rs2;
        logic [4:0] rs1;
        logic [2:0] funct3;
        logic [4:0] rd;
        logic [6:0] opcode;
    } r_fmt_t;

    typedef struct packed {
        logic [11:0] imm12;
        logic [4:0]  rs1;
        logic [2:0]  funct3;
        logic [4:0]  rd;
        logic [6:0]  opcode;
    } i_fmt_t;

    typedef struct packed {
        logic [6:0] imm_hi;
        logic [4:0] rs2;
        logic [4:0] rs1;
        logic [2:0] funct3;
        logic [4:0] imm_lo;
        logic [6:0] opcode;
    } s_fmt_t;

    typedef struct packed {
        logic [19:0] imm20;
        logic [4:0]  rd;
        logic [6:0]  opcode;
    } u_fmt_t;

    // one instruction word, viewed by format
    typedef union packed {
        r_fmt_t r;
        i_fmt_t i;
        s_fmt_t s;
        u_fmt_t u;
    } instr_u;

endpackage

`default_nettype wire

// File: common/core_settings.svh
`ifndef CORE_SETTINGS_SVH
`define CORE_SETTINGS_SVH

////////////////////////////////////////////////////////////////////////////
// minirv core sizing
////////////////////////////////////////////////////////////////////////////

// RV32E has sixteen architectural registers
`define MINIRV_NREGS 16

// data memory depth in 32-bit words
`define MINIRV_DMEM_WORDS 256

`define MINIRV_RESET_PC 32'h0000_0000 // first fetch address after reset

`endif
